//--- src/tacho_pkg.sv
// bus widths, 0x8xx register map and struct types for a two-pair tacho simulator; 16-bit bus only
package tacho_pkg;

  // ------------------------------
  // bus and design sizes
  localparam int ADDR_W    = 12;
  localparam int DATA_W    = 16;
  localparam int NUM_PAIRS = 2;
  localparam int CFG_W     = 32;   // frequency / phase word, low + high register

  localparam logic [3:0]        FPGA_WIN     = 4'h8;      // upper nibble of our window
  localparam logic [DATA_W-1:0] VERSION_WORD = 16'hb825;

  // per-pair address steps
  localparam int PAIR_CFG_STRIDE = 4;   // fcfg / pcfg pairs
  localparam int PAIR_WORD_STEP  = 2;   // low to high word
  localparam int PULSE_STRIDE    = 2;   // pulse-count registers

  // ------------------------------
  // register map
  localparam logic [ADDR_W-1:0] ADDR_VER        = 12'h800;
  localparam logic [ADDR_W-1:0] ADDR_AAAA       = 12'h802;
  localparam logic [ADDR_W-1:0] ADDR_5555       = 12'h804;
  localparam logic [ADDR_W-1:0] ADDR_FFFF       = 12'h806;
  localparam logic [ADDR_W-1:0] ADDR_0000       = 12'h808;

  localparam logic [ADDR_W-1:0] ADDR_SPD_MODE   = 12'h810;  // bit per pair, 1 = limited
  localparam logic [ADDR_W-1:0] ADDR_OUT_CTRL   = 12'h812;  // bit per channel
  localparam logic [ADDR_W-1:0] ADDR_SPD_LOAD   = 12'h814;  // bit per pair

  localparam logic [ADDR_W-1:0] ADDR_FCFG_BASE  = 12'h820;
  localparam logic [ADDR_W-1:0] ADDR_PCFG_BASE  = 12'h840;  // bit 31 set = channel b leads
  localparam logic [ADDR_W-1:0] ADDR_PULSE_BASE = 12'h860;
  localparam logic [ADDR_W-1:0] ADDR_FINISHED   = 12'h870;  // read only

  // ------------------------------
  // one decoded bus access, from the synchronizer to the register bank
  typedef struct packed {
    logic              wr;        // one clock per write strobe
    logic              rd;        // one clock per read strobe
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              sel;       // chip select, synchronized, active high
    logic              rd_level;  // raw read strobe, active high
  } lbus_req_t;

  // configuration of one pulse pair
  typedef struct packed {
    logic [CFG_W-1:0]  half_period;
    logic [CFG_W-1:0]  phase;
    logic [DATA_W-1:0] pulse_limit;
    logic              limited;
    logic              enable;
    logic              load;       // one clock pulse
  } pair_cfg_t;

endpackage

//--- src/lbus_sync.sv
// strobes need at least 4 clocks low and 4 high; la and ld_in must stay stable while a strobe is low
`timescale 1ns/10ps

module lbus_sync (
  input  logic                         W_clk,
  input  logic                         W_reset_n,
  input  logic                         lcs_n,
  input  logic                         lrd_n,
  input  logic                         lwr_n,
  input  logic [tacho_pkg::ADDR_W-1:0] la,
  input  logic [tacho_pkg::DATA_W-1:0] ld_in,
  output tacho_pkg::lbus_req_t         req
);

  logic cs_q;          // chip select, one stage
  logic rd_q, rd_qq;   // read strobe, sync + previous
  logic wr_q, wr_qq;   // write strobe, sync + previous

  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      cs_q  <= 1'b1;   // bus idles high
      rd_q  <= 1'b1;
      rd_qq <= 1'b1;
      wr_q  <= 1'b1;
      wr_qq <= 1'b1;
    end
    else
    begin
      cs_q  <= lcs_n;
      rd_q  <= lrd_n;
      rd_qq <= rd_q;
      wr_q  <= lwr_n;
      wr_qq <= wr_q;
    end
  end

  // falling edge of each strobe while selected
  assign req.sel      = !cs_q;
  assign req.rd       = !cs_q && !rd_q && rd_qq;
  assign req.wr       = !cs_q && !wr_q && wr_qq;

  // address and data go through as is, the host holds them
  assign req.addr     = la;
  assign req.wdata    = ld_in;
  assign req.rd_level = !lrd_n;

endmodule

//--- src/tacho_regs.sv
// unmapped reads return the previous read data; writes to read-only or unmapped addresses are ignored
`timescale 1ns/10ps

module tacho_regs (
  input  logic                                              W_clk,
  input  logic                                              W_reset_n,
  input  tacho_pkg::lbus_req_t                              req,
  input  logic [tacho_pkg::NUM_PAIRS-1:0]                   finished,
  output tacho_pkg::pair_cfg_t [tacho_pkg::NUM_PAIRS-1:0]   cfg,
  output logic [2*tacho_pkg::NUM_PAIRS-1:0]                 out_ctrl,
  output logic [tacho_pkg::DATA_W-1:0]                      ld_out,
  output logic                                              ld_oe
);

  import tacho_pkg::*;

  logic [DATA_W-1:0]    fcfg_lo [NUM_PAIRS];
  logic [DATA_W-1:0]    fcfg_hi [NUM_PAIRS];
  logic [DATA_W-1:0]    pcfg_lo [NUM_PAIRS];
  logic [DATA_W-1:0]    pcfg_hi [NUM_PAIRS];
  logic [DATA_W-1:0]    pulse_num [NUM_PAIRS];
  logic [NUM_PAIRS-1:0] spd_mode;
  logic [NUM_PAIRS-1:0] spd_load;     // kept readable
  logic [NUM_PAIRS-1:0] load_pulse;
  logic [NUM_PAIRS-1:0] finished_q;
  logic [DATA_W-1:0]    rd_mux;
  logic [DATA_W-1:0]    rd_data;

  // address of word w of pair p in a per-pair block
  function automatic logic [ADDR_W-1:0] pair_addr(input logic [ADDR_W-1:0] base,
                                                  input int stride,
                                                  input int p,
                                                  input int w);
    pair_addr = base + ADDR_W'(stride * p + PAIR_WORD_STEP * w);
  endfunction

  // ------------------------------
  // write decode
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      for (int p = 0; p < NUM_PAIRS; p++)
      begin
        fcfg_lo[p]   <= '0;
        fcfg_hi[p]   <= '0;
        pcfg_lo[p]   <= '0;
        pcfg_hi[p]   <= '0;
        pulse_num[p] <= '0;
      end
      spd_mode   <= '0;
      spd_load   <= '0;
      out_ctrl   <= '0;
      load_pulse <= '0;
    end
    else
    begin
      load_pulse <= '0;   // one clock only
      if (req.wr)
      begin
        case (req.addr)
          ADDR_SPD_MODE: spd_mode <= req.wdata[NUM_PAIRS-1:0];
          ADDR_OUT_CTRL: out_ctrl <= req.wdata[2*NUM_PAIRS-1:0];
          ADDR_SPD_LOAD:
          begin
            spd_load   <= req.wdata[NUM_PAIRS-1:0];
            load_pulse <= req.wdata[NUM_PAIRS-1:0];   // restarts the pairs with a 1
          end
          default: ;
        endcase
        for (int p = 0; p < NUM_PAIRS; p++)
        begin
          if (req.addr == pair_addr(ADDR_FCFG_BASE, PAIR_CFG_STRIDE, p, 0))
            fcfg_lo[p] <= req.wdata;
          if (req.addr == pair_addr(ADDR_FCFG_BASE, PAIR_CFG_STRIDE, p, 1))
            fcfg_hi[p] <= req.wdata;
          if (req.addr == pair_addr(ADDR_PCFG_BASE, PAIR_CFG_STRIDE, p, 0))
            pcfg_lo[p] <= req.wdata;
          if (req.addr == pair_addr(ADDR_PCFG_BASE, PAIR_CFG_STRIDE, p, 1))
            pcfg_hi[p] <= req.wdata;
          if (req.addr == pair_addr(ADDR_PULSE_BASE, PULSE_STRIDE, p, 0))
            pulse_num[p] <= req.wdata;
        end
      end
    end
  end

  // ------------------------------
  // read back
  always_comb
  begin
    rd_mux = rd_data;   // unmapped, hold
    case (req.addr)
      ADDR_VER:      rd_mux = VERSION_WORD;
      ADDR_AAAA:     rd_mux = 16'haaaa;
      ADDR_5555:     rd_mux = 16'h5555;
      ADDR_FFFF:     rd_mux = 16'hffff;
      ADDR_0000:     rd_mux = 16'h0000;
      ADDR_SPD_MODE: rd_mux = DATA_W'(spd_mode);
      ADDR_OUT_CTRL: rd_mux = DATA_W'(out_ctrl);
      ADDR_SPD_LOAD: rd_mux = DATA_W'(spd_load);
      ADDR_FINISHED: rd_mux = DATA_W'(finished_q);
      default: ;
    endcase
    for (int p = 0; p < NUM_PAIRS; p++)
    begin
      if (req.addr == pair_addr(ADDR_FCFG_BASE, PAIR_CFG_STRIDE, p, 0))
        rd_mux = fcfg_lo[p];
      if (req.addr == pair_addr(ADDR_FCFG_BASE, PAIR_CFG_STRIDE, p, 1))
        rd_mux = fcfg_hi[p];
      if (req.addr == pair_addr(ADDR_PCFG_BASE, PAIR_CFG_STRIDE, p, 0))
        rd_mux = pcfg_lo[p];
      if (req.addr == pair_addr(ADDR_PCFG_BASE, PAIR_CFG_STRIDE, p, 1))
        rd_mux = pcfg_hi[p];
      if (req.addr == pair_addr(ADDR_PULSE_BASE, PULSE_STRIDE, p, 0))
        rd_mux = pulse_num[p];
    end
  end

  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      rd_data    <= '0;
      finished_q <= '0;
    end
    else
    begin
      finished_q <= finished;
      if (req.rd)
        rd_data <= rd_mux;   // same edge as a write would land
    end
  end

  assign ld_out = rd_data;
  assign ld_oe  = req.sel && req.rd_level && (req.addr[ADDR_W-1 -: 4] == FPGA_WIN);

  // ------------------------------
  // per-pair configuration
  always_comb
  begin
    for (int p = 0; p < NUM_PAIRS; p++)
    begin
      cfg[p].half_period = {fcfg_hi[p], fcfg_lo[p]};
      cfg[p].phase       = {pcfg_hi[p], pcfg_lo[p]};
      cfg[p].pulse_limit = pulse_num[p];
      cfg[p].limited     = spd_mode[p];
      cfg[p].enable      = out_ctrl[2*p] | out_ctrl[2*p+1];   // runs if either channel is on
      cfg[p].load        = load_pulse[p];
    end
  end

endmodule

//--- src/pulse_pair_gen.sv
// starts only on a load while enabled; half_period 0 behaves as 1; limited mode with limit 0 ends at once
`timescale 1ns/10ps

module pulse_pair_gen (
  input  logic                 W_clk,
  input  logic                 W_reset_n,
  input  tacho_pkg::pair_cfg_t cfg,
  output logic                 chan_a,
  output logic                 chan_b,
  output logic                 finished
);

  import tacho_pkg::*;

  localparam int DLY_W = CFG_W - 1;   // phase without the lead bit

  // index 0 is the leading channel, index 1 the lagging one
  logic [1:0]        run;
  logic [1:0]        level;
  logic [1:0]        done;
  logic [CFG_W-1:0]  hp_cnt [2];      // clocks in the current half period
  logic [DATA_W-1:0] rise_cnt [2];    // rising edges since load
  logic [DLY_W-1:0]  dly_cnt;
  logic              dly_active;
  logic              b_leads;         // latched phase bit 31
  logic [DLY_W-1:0]  phase_cnt;
  logic              start_ok;

  assign phase_cnt = cfg.phase[DLY_W-1:0];
  assign start_ok  = !(cfg.limited && (cfg.pulse_limit == '0));

  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      run        <= '0;
      level      <= '0;
      done       <= '0;
      dly_cnt    <= '0;
      dly_active <= 1'b0;
      b_leads    <= 1'b0;
      for (int c = 0; c < 2; c++)
      begin
        hp_cnt[c]   <= '0;
        rise_cnt[c] <= '0;
      end
    end
    else if (!cfg.enable)
    begin
      // both low, finished flag kept until the next load
      run        <= '0;
      level      <= '0;
      dly_active <= 1'b0;
    end
    else if (cfg.load)
    begin
      b_leads     <= cfg.phase[CFG_W-1];
      done        <= start_ok ? 2'b00 : 2'b11;
      run[0]      <= start_ok;
      level[0]    <= start_ok;   // lead goes high right away
      run[1]      <= start_ok && (phase_cnt == '0);
      level[1]    <= start_ok && (phase_cnt == '0);
      dly_cnt     <= phase_cnt;
      dly_active  <= start_ok && (phase_cnt != '0);
      for (int c = 0; c < 2; c++)
      begin
        hp_cnt[c]   <= CFG_W'(1);
        rise_cnt[c] <= DATA_W'(1);   // the start counts as the first rise
      end
    end
    else
    begin
      // ------------------------------
      // half-period toggling, per channel
      for (int c = 0; c < 2; c++)
      begin
        if (run[c])
        begin
          if (hp_cnt[c] >= cfg.half_period)
          begin
            hp_cnt[c] <= CFG_W'(1);
            if (level[c])
            begin
              level[c] <= 1'b0;
              // each channel ends low after its own last pulse
              if (cfg.limited && (rise_cnt[c] >= cfg.pulse_limit))
              begin
                run[c]  <= 1'b0;
                done[c] <= 1'b1;
              end
            end
            else
            begin
              level[c]    <= 1'b1;
              rise_cnt[c] <= rise_cnt[c] + DATA_W'(1);
            end
          end
          else
            hp_cnt[c] <= hp_cnt[c] + CFG_W'(1);
        end
      end

      // phase delay before the lagging channel starts
      if (dly_active)
      begin
        if (dly_cnt == DLY_W'(1))
        begin
          dly_active <= 1'b0;
          run[1]     <= 1'b1;
          level[1]   <= 1'b1;
          hp_cnt[1]  <= CFG_W'(1);
        end
        else
          dly_cnt <= dly_cnt - DLY_W'(1);
      end
    end
  end

  assign chan_a   = b_leads ? level[1] : level[0];
  assign chan_b   = b_leads ? level[0] : level[1];
  assign finished = &done;   // set once the later channel has stopped

endmodule

//--- src/tacho_top.sv
// two pulse pairs behind a 16-bit async local bus; read data is split into ld_out and ld_oe, no tristate
`timescale 1ns/10ps

module tacho_top (
  input  logic                            W_clk,
  input  logic                            W_reset_n,
  input  logic                            lcs_n,
  input  logic                            lrd_n,
  input  logic                            lwr_n,
  input  logic [tacho_pkg::ADDR_W-1:0]    la,
  input  logic [tacho_pkg::DATA_W-1:0]    ld_in,
  output logic [tacho_pkg::DATA_W-1:0]    ld_out,
  output logic                            ld_oe,
  output logic [tacho_pkg::NUM_PAIRS-1:0] spd_a,
  output logic [tacho_pkg::NUM_PAIRS-1:0] spd_b
);

  import tacho_pkg::*;

  lbus_req_t                 req;
  pair_cfg_t [NUM_PAIRS-1:0] cfg;
  logic [2*NUM_PAIRS-1:0]    out_ctrl;
  logic [NUM_PAIRS-1:0]      finished;
  logic [NUM_PAIRS-1:0]      chan_a;
  logic [NUM_PAIRS-1:0]      chan_b;

  // ------------------------------
  // bus side
  lbus_sync u_sync (
    .W_clk     (W_clk),
    .W_reset_n (W_reset_n),
    .lcs_n     (lcs_n),
    .lrd_n     (lrd_n),
    .lwr_n     (lwr_n),
    .la        (la),
    .ld_in     (ld_in),
    .req       (req)
  );

  tacho_regs u_regs (
    .W_clk     (W_clk),
    .W_reset_n (W_reset_n),
    .req       (req),
    .finished  (finished),
    .cfg       (cfg),
    .out_ctrl  (out_ctrl),
    .ld_out    (ld_out),
    .ld_oe     (ld_oe)
  );

  // ------------------------------
  // generators and channel gating
  for (genvar i = 0; i < NUM_PAIRS; i++)
  begin : g_pair
    pulse_pair_gen u_pair (
      .W_clk     (W_clk),
      .W_reset_n (W_reset_n),
      .cfg       (cfg[i]),
      .chan_a    (chan_a[i]),
      .chan_b    (chan_b[i]),
      .finished  (finished[i])
    );

    assign spd_a[i] = chan_a[i] & out_ctrl[2*i];     // even bit, channel a
    assign spd_b[i] = chan_b[i] & out_ctrl[2*i+1];   // odd bit, channel b
  end

endmodule

//--- testbench/tb_clkgen.sv
// free-running 40 ns clock; reset low for the first 2 rising edges, released 2 ns after the second
`timescale 1ns/10ps

module tb_clkgen (
  output logic W_clk,
  output logic W_reset_n
);

  localparam int HALF_NS = 20;

  initial
  begin
    W_clk     = 1'b0;
    W_reset_n = 1'b0;
    repeat (2) @(posedge W_clk);
    #2 W_reset_n = 1'b1;
  end

  always #HALF_NS W_clk = ~W_clk;

endmodule

//--- testbench/tb_checker.sv
// samples on the rising clock only; keeps at most 64 rise times per channel between arm and measure
`timescale 1ns/10ps

module tb_checker (
  input  logic        W_clk,
  input  logic [15:0] ld_out,
  input  logic        ld_oe,
  input  logic [1:0]  spd_a,
  input  logic [1:0]  spd_b,
  input  logic        rd_chk,     // last clock of a read strobe
  input  logic [11:0] rd_addr,
  input  logic [15:0] rd_exp,
  input  logic        arm,        // restart edge capture of arm_pair
  input  logic        arm_pair,
  input  logic        meas,       // compare capture of m_pair
  input  logic        m_pair,
  input  int          m_period,   // -1 skips
  input  int          m_phase,    // 9999 skips, negative means b leads
  input  int          m_acnt,
  input  int          m_bcnt,
  output int          n_tests,
  output int          n_fail
);

  localparam int MAX_T = 64;

  int         cyc;
  int         a_t [2][MAX_T];
  int         b_t [2][MAX_T];
  int         a_n [2];
  int         b_n [2];
  logic [1:0] armed;
  logic [1:0] a_prev;
  logic [1:0] b_prev;

  initial
  begin
    cyc     = 0;
    n_tests = 0;
    n_fail  = 0;
    armed   = '0;
    a_prev  = '0;
    b_prev  = '0;
    for (int p = 0; p < 2; p++)
    begin
      a_n[p] = 0;
      b_n[p] = 0;
    end
  end

  task automatic check_read();
    bit ok;
    ok = 1;
    if (ld_out !== rd_exp)
    begin
      $display("CHECK FAILED at %0t: ld_out expected %h got %h", $time, rd_exp, ld_out);
      ok = 0;
    end
    if (ld_oe !== 1'b1)
    begin
      $display("CHECK FAILED at %0t: ld_oe expected 1 got %b", $time, ld_oe);
      ok = 0;
    end
    n_tests++;
    if (!ok)
      n_fail++;
    $display("read 0x%h: %s", rd_addr, ok ? "ok" : "mismatch");
  endtask

  task automatic check_measure();
    int  p;
    int  ka;
    int  kb;
    int  d;
    int  best;
    int  got;
    bit  ok;
    p  = int'(m_pair);
    ok = 1;
    ka = (a_n[p] < MAX_T) ? a_n[p] : MAX_T;
    kb = (b_n[p] < MAX_T) ? b_n[p] : MAX_T;
    if (m_acnt >= 0 && a_n[p] != m_acnt)
    begin
      $display("CHECK FAILED at %0t: spd_a[%0d] pulses expected %0d got %0d",
               $time, p, m_acnt, a_n[p]);
      ok = 0;
    end
    if (m_bcnt >= 0 && b_n[p] != m_bcnt)
    begin
      $display("CHECK FAILED at %0t: spd_b[%0d] pulses expected %0d got %0d",
               $time, p, m_bcnt, b_n[p]);
      ok = 0;
    end
    if (m_acnt == 0 && spd_a[p] !== 1'b0)
    begin
      $display("CHECK FAILED at %0t: spd_a[%0d] expected 0 got %b", $time, p, spd_a[p]);
      ok = 0;
    end
    if (m_bcnt == 0 && spd_b[p] !== 1'b0)
    begin
      $display("CHECK FAILED at %0t: spd_b[%0d] expected 0 got %b", $time, p, spd_b[p]);
      ok = 0;
    end
    if (ld_oe !== 1'b0)   // no strobe during a measure
    begin
      $display("CHECK FAILED at %0t: ld_oe expected 0 got %b", $time, ld_oe);
      ok = 0;
    end
    if (m_period >= 0)
    begin
      if (ka < 3)
      begin
        $display("pair %0d: too few rising edges on spd_a to measure the period", p);
        ok = 0;
      end
      else
      begin
        got = a_t[p][ka-1] - a_t[p][ka-2];
        if (got != m_period)
        begin
          $display("CHECK FAILED at %0t: spd_a[%0d] period expected %0d got %0d",
                   $time, p, m_period, got);
          ok = 0;
        end
      end
    end
    if (m_phase != 9999)
    begin
      if (ka < 2 || kb < 1)
      begin
        $display("pair %0d: no edge pair on spd_a and spd_b to measure the phase", p);
        ok = 0;
      end
      else
      begin
        // nearest b rise to the second last a rise, so later b edges exist too
        best = 1 << 30;
        for (int j = 0; j < kb; j++)
        begin
          d = b_t[p][j] - a_t[p][ka-2];
          if ((d < 0 ? -d : d) < (best < 0 ? -best : best))
            best = d;
        end
        if (best != m_phase)
        begin
          $display("CHECK FAILED at %0t: spd_b[%0d] phase expected %0d got %0d",
                   $time, p, m_phase, best);
          ok = 0;
        end
      end
    end
    n_tests++;
    if (!ok)
      n_fail++;
    $display("measure pair %0d: %s", p, ok ? "ok" : "mismatch");
  endtask

  // ------------------------------
  // edge capture and compare
  always @(posedge W_clk)
  begin
    cyc++;
    for (int p = 0; p < 2; p++)
    begin
      if (armed[p] && spd_a[p] && !a_prev[p])
      begin
        if (a_n[p] < MAX_T)
          a_t[p][a_n[p]] = cyc;
        a_n[p]++;
      end
      if (armed[p] && spd_b[p] && !b_prev[p])
      begin
        if (b_n[p] < MAX_T)
          b_t[p][b_n[p]] = cyc;
        b_n[p]++;
      end
    end
    a_prev = spd_a;
    b_prev = spd_b;
    if (arm)
    begin
      armed[arm_pair] = 1'b1;
      a_n[arm_pair]   = 0;   // fresh capture
      b_n[arm_pair]   = 0;
    end
    if (rd_chk)
      check_read();
    if (meas)
      check_measure();
  end

endmodule

//--- testbench/tb_top.sv
// runs testbench/tacho_trace.txt from the project root; at most 256 trace lines
`timescale 1ns/10ps

module tb_top;

  localparam int IO_DLY  = 2;     // ns after the rising edge
  localparam int STROBE  = 6;
  localparam int GAP     = 4;
  localparam int MAX_OPS = 256;

  logic        W_clk;
  logic        W_reset_n;
  logic        lcs_n;
  logic        lrd_n;
  logic        lwr_n;
  logic [11:0] la;
  logic [15:0] ld_in;
  logic [15:0] ld_out;
  logic        ld_oe;
  logic [1:0]  spd_a;
  logic [1:0]  spd_b;
  logic        rd_chk;
  logic [15:0] rd_exp;
  logic        arm;
  logic        arm_pair;
  logic        meas;
  logic        m_pair;
  int          m_period;
  int          m_phase;
  int          m_acnt;
  int          m_bcnt;
  int          n_tests;
  int          n_fail;

  string ops [MAX_OPS];
  int    fv  [MAX_OPS][5];
  int    n_ops;
  int    trace_cycles;
  bit    trace_ready;

  tb_clkgen u_clk (.W_clk(W_clk), .W_reset_n(W_reset_n));

  tacho_top u_dut (
    .W_clk(W_clk), .W_reset_n(W_reset_n), .lcs_n(lcs_n), .lrd_n(lrd_n), .lwr_n(lwr_n),
    .la(la), .ld_in(ld_in), .ld_out(ld_out), .ld_oe(ld_oe), .spd_a(spd_a), .spd_b(spd_b)
  );

  tb_checker u_chk (
    .W_clk(W_clk), .ld_out(ld_out), .ld_oe(ld_oe), .spd_a(spd_a), .spd_b(spd_b),
    .rd_chk(rd_chk), .rd_addr(la), .rd_exp(rd_exp), .arm(arm), .arm_pair(arm_pair),
    .meas(meas), .m_pair(m_pair), .m_period(m_period), .m_phase(m_phase),
    .m_acnt(m_acnt), .m_bcnt(m_bcnt), .n_tests(n_tests), .n_fail(n_fail)
  );

  // ------------------------------
  // trace loading, cycles per op summed for the watchdog
  task automatic read_trace();
    int    fd;
    int    r;
    string line;
    string tok;
    fd = $fopen("testbench/tacho_trace.txt", "r");
    if (fd == 0)
      $display("cannot open testbench/tacho_trace.txt, no tests run");
    else
    begin
      while (!$feof(fd) && n_ops < MAX_OPS)
      begin
        line = "";
        r = $fgets(line, fd);
        if ($sscanf(line, "%s", tok) == 1 && tok[0] != "#")
        begin
          if (tok == "W" || tok == "R")
          begin
            r = $sscanf(line, "%s %h %h", tok, fv[n_ops][0], fv[n_ops][1]);
            trace_cycles += STROBE + GAP;
          end
          else
          begin
            r = $sscanf(line, "%s %d %d %d %d %d", tok, fv[n_ops][0], fv[n_ops][1],
                        fv[n_ops][2], fv[n_ops][3], fv[n_ops][4]);
            trace_cycles += (tok == "D") ? fv[n_ops][0] : 1;
          end
          ops[n_ops] = tok;
          n_ops++;
        end
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------
  // bus cycles, each starts and ends IO_DLY after an edge
  task automatic bus_write(input int addr, input int data);
    la    = addr[11:0];
    ld_in = data[15:0];
    lcs_n = 1'b0;
    lwr_n = 1'b0;
    repeat (STROBE) @(posedge W_clk);
    #IO_DLY;
    lwr_n = 1'b1;
    lcs_n = 1'b1;
    repeat (GAP) @(posedge W_clk);
    #IO_DLY;
  endtask

  task automatic bus_read(input int addr, input int expect_val);
    la     = addr[11:0];
    rd_exp = expect_val[15:0];
    lcs_n  = 1'b0;
    lrd_n  = 1'b0;
    repeat (STROBE - 1) @(posedge W_clk);
    #IO_DLY rd_chk = 1'b1;   // checker samples at the last strobe edge
    @(posedge W_clk);
    #IO_DLY;
    rd_chk = 1'b0;
    lrd_n  = 1'b1;
    lcs_n  = 1'b1;
    repeat (GAP) @(posedge W_clk);
    #IO_DLY;
  endtask

  task automatic pulse_arm(input int p);
    arm_pair = p[0];
    arm      = 1'b1;
    @(posedge W_clk);
    #IO_DLY arm = 1'b0;
  endtask

  task automatic pulse_measure(input int i);
    m_pair   = fv[i][0][0];
    m_period = fv[i][1];
    m_phase  = fv[i][2];
    m_acnt   = fv[i][3];
    m_bcnt   = fv[i][4];
    meas     = 1'b1;
    @(posedge W_clk);
    #IO_DLY meas = 1'b0;
  endtask

  initial
  begin
    lcs_n    = 1'b1;
    lrd_n    = 1'b1;
    lwr_n    = 1'b1;
    la       = '0;
    ld_in    = '0;
    rd_chk   = 1'b0;
    rd_exp   = '0;
    arm      = 1'b0;
    arm_pair = 1'b0;
    meas     = 1'b0;
    m_pair   = 1'b0;
    m_period = -1;
    m_phase  = 9999;
    m_acnt   = -1;
    m_bcnt   = -1;
    n_ops        = 0;
    trace_cycles = 0;
    read_trace();
    trace_ready = 1'b1;
    @(posedge W_reset_n);
    @(posedge W_clk);
    #IO_DLY;
    for (int i = 0; i < n_ops; i++)
    begin
      if (ops[i] == "W")
        bus_write(fv[i][0], fv[i][1]);
      else if (ops[i] == "R")
        bus_read(fv[i][0], fv[i][1]);
      else if (ops[i] == "A")
        pulse_arm(fv[i][0]);
      else if (ops[i] == "M")
        pulse_measure(i);
      else if (ops[i] == "D")
      begin
        repeat (fv[i][0]) @(posedge W_clk);
        #IO_DLY;
      end
      else
        $display("unknown trace op %s ignored", ops[i]);
    end
    repeat (4) @(posedge W_clk);
    $display("tests %0d, failed %0d", n_tests, n_fail);
    if (n_fail == 0 && n_tests > 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // watchdog, twice the trace length plus slack
  initial
  begin
    int limit;
    wait (trace_ready);
    limit = 2 * trace_cycles + 200;
    repeat (limit) @(posedge W_clk);
    $display("timeout, the trace did not finish within %0d clocks", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- testbench/tacho_trace.txt
# W addr data | R addr expected (hex) | A pair | D clocks
# M pair period phase a_pulses b_pulses (decimal, -1 or phase 9999 skips)
A 0
A 1
D 20
M 0 -1 9999 0 0
M 1 -1 9999 0 0
R 800 b825
R 802 aaaa
R 804 5555
R 806 ffff
R 808 0000
W 820 0005
W 822 0000
W 840 0003
W 842 0000
W 812 000f
R 820 0005
R 840 0003
R 812 000f
W 824 0003
W 862 0004
W 810 0002
R 862 0004
R 810 0002
A 0
W 814 0001
D 60
M 0 10 3 -1 -1
A 1
W 814 0002
D 60
M 1 6 0 4 4
R 870 0002
W 812 000d
A 0
D 40
M 0 10 9999 -1 0
W 812 000f
W 842 8000
R 842 8000
A 0
W 814 0001
D 60
M 0 10 -3 -1 -1
R 814 0001

//--- tb.f
src/tacho_pkg.sv
src/lbus_sync.sv
src/tacho_regs.sv
src/pulse_pair_gen.sv
src/tacho_top.sv
testbench/tb_clkgen.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_top
FILELIST = tb.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(wildcard src/*.sv testbench/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN) testbench/tacho_trace.txt
	./$(BIN) | tee $(LOG)
	@if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then exit 1; fi
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
